// File: rtl/msx_storage_consts.svh
// Width, cassette download index and SD activity hold constants
`ifndef MSX_STORAGE_CONSTS_SVH
`define MSX_STORAGE_CONSTS_SVH

// ==========================================================================
// Host download and image mount widths
// ==========================================================================
`define IMG_SIZE_W        64
`define IOCTL_INDEX_W     16

// ==========================================================================
// Cassette file download
// ==========================================================================
// Only the low index bits identify the file slot
`define CAS_INDEX_BITS    6
`define CAS_IOCTL_INDEX   5

// ==========================================================================
// SD activity detection
// ==========================================================================
// Quiet cycles before the disk LED goes dark
`define SD_ACT_HOLD       4096
// Counter must reach SD_ACT_HOLD itself
`define SD_ACT_CNT_W      13

`endif

// File: rtl/msx_storage_pkg.sv
// Storage vector typedefs, disk LED control word and tape state enum
`include "msx_storage_consts.svh"

package msx_storage_pkg;

   // ========================================================================
   // Vectors with a meaning
   // ========================================================================

   // Byte size of a mounted virtual card image
   typedef logic [`IMG_SIZE_W-1:0] img_size_t;

   // File slot of a host download
   typedef logic [`IOCTL_INDEX_W-1:0] ioctl_index_t;

   // Quiet cycle counter of the activity monitor
   typedef logic [`SD_ACT_CNT_W-1:0] act_count_t;

   // Disk LED word
   // bit 1 set gives the core sole control, bit 0 is the LED state
   typedef logic [1:0] led_disk_t;

   // ========================================================================
   // Cassette control
   // ========================================================================

   typedef enum logic [1:0] {
      TAPE_EMPTY,
      TAPE_LOADING,
      TAPE_READY
   } tape_state_t;

endpackage

// File: rtl/spi_bus_if.sv
// SPI link interface with master, slave and monitor modports
`timescale 1ns/1ps

interface spi_bus_if;

   // Master to slave
   logic sck;
   logic mosi;
   logic ss;
   // High while the master wants the bus
   logic enable;

   // Slave to master
   logic miso;

   modport master (
      output sck,
      output mosi,
      output ss,
      output enable,
      input  miso
   );

   modport slave (
      input  sck,
      input  mosi,
      input  ss,
      input  enable,
      output miso
   );

   // Passive tap on the data lines only
   modport monitor (
      input mosi,
      input miso
   );

endinterface

// File: rtl/sd_source_select.sv
// SPI master selection and virtual card mount register
`timescale 1ns/1ps

module sd_source_select (
   input  logic                       clock_bus,
   input  logic                       rst,
   spi_bus_if.slave                   ese,
   spi_bus_if.slave                   megasd,
   spi_bus_if.master                  merged,
   input  logic                       img_mounted,
   input  msx_storage_pkg::img_size_t img_size,
   output logic                       vsd_sel
);

   // =======================================================================
   // Master merge
   // =======================================================================

   // Expansion slot master wins whenever it raises enable
   assign merged.sck  = ese.enable ? ese.sck  : megasd.sck;
   assign merged.mosi = ese.enable ? ese.mosi : megasd.mosi;

   // MegaSD has no select line of its own, card stays selected (low)
   assign merged.ss   = ese.enable ? ese.ss : 1'b0;

   // Owner flag of the merged bus
   assign merged.enable = ese.enable;

   // Both masters see the card reply
   assign ese.miso    = merged.miso;
   assign megasd.miso = merged.miso;

   // =======================================================================
   // Virtual card mount
   // =======================================================================

   // Non-zero image picks the virtual card, empty mount returns to socket
   always_ff @(posedge clock_bus) begin
      if (rst) begin
         vsd_sel <= 1'b0;
      end else if (img_mounted) begin
         vsd_sel <= |img_size;
      end
   end

endmodule

// File: rtl/sd_activity_monitor.sv
// SD data line toggle detector with activity hold counter
`timescale 1ns/1ps
`include "msx_storage_consts.svh"

module sd_activity_monitor (
   input  logic       clock_bus,
   input  logic       rst,
   spi_bus_if.monitor bus,
   output logic       sd_act
);

   localparam msx_storage_pkg::act_count_t HOLD_COUNT =
      msx_storage_pkg::act_count_t'(`SD_ACT_HOLD);

   logic                        old_mosi;
   logic                        old_miso;
   logic                        toggle;
   msx_storage_pkg::act_count_t quiet_count;

   // Previous line levels
   always_ff @(posedge clock_bus) begin
      old_mosi <= bus.mosi;
      old_miso <= bus.miso;
   end

   assign toggle = (old_mosi ^ bus.mosi) | (old_miso ^ bus.miso);

   // Counter saturates at the hold value, any edge restarts it
   always_ff @(posedge clock_bus) begin
      if (rst) begin
         quiet_count <= HOLD_COUNT;
         sd_act      <= 1'b0;
      end else begin
         sd_act <= quiet_count < HOLD_COUNT;
         if (toggle) begin
            quiet_count <= '0;
         end else if (quiet_count < HOLD_COUNT) begin
            quiet_count <= quiet_count + 1'b1;
         end
      end
   end

endmodule

// File: rtl/tape_control.sv
// Cassette download tracking FSM with play, rewind and enable outputs
`timescale 1ns/1ps
`include "msx_storage_consts.svh"

module tape_control (
   input  logic                          clock_bus,
   input  logic                          rst,
   input  logic                          ioctl_download,
   input  msx_storage_pkg::ioctl_index_t ioctl_index,
   input  logic                          tape_rewind_req,
   input  logic                          cas_motor,
   output logic                          tape_play,
   output logic                          tape_rewind,
   output logic                          tape_enable
);

   msx_storage_pkg::tape_state_t state;
   msx_storage_pkg::tape_state_t state_next;
   logic                         cas_download;

   // Cassette file is identified by the low index bits only
   assign cas_download = ioctl_download &&
      (ioctl_index[`CAS_INDEX_BITS-1:0] == `CAS_INDEX_BITS'(`CAS_IOCTL_INDEX));

   always_comb begin
      state_next = state;
      case (state)
         msx_storage_pkg::TAPE_EMPTY: begin
            if (cas_download) state_next = msx_storage_pkg::TAPE_LOADING;
         end
         msx_storage_pkg::TAPE_LOADING: begin
            if (!cas_download) state_next = msx_storage_pkg::TAPE_READY;
         end
         msx_storage_pkg::TAPE_READY: begin
            // New file replaces the loaded one
            if (cas_download) state_next = msx_storage_pkg::TAPE_LOADING;
         end
         default: begin
            state_next = msx_storage_pkg::TAPE_EMPTY;
         end
      endcase
   end

   // Outputs decode the next state so they land with the state change
   always_ff @(posedge clock_bus) begin
      if (rst) begin
         state       <= msx_storage_pkg::TAPE_EMPTY;
         tape_play   <= 1'b0;
         tape_rewind <= 1'b0;
         tape_enable <= 1'b0;
      end else begin
         state       <= state_next;
         tape_rewind <= tape_rewind_req | (state_next == msx_storage_pkg::TAPE_LOADING);
         tape_enable <= state_next == msx_storage_pkg::TAPE_READY;
         // Motor relay on stops the player
         tape_play   <= (state_next == msx_storage_pkg::TAPE_READY) & ~cas_motor;
      end
   end

endmodule

// File: rtl/sd_port_mux.sv
// Physical and virtual SD card pin steering, MISO return and LED drive
`timescale 1ns/1ps

module sd_port_mux (
   spi_bus_if.slave                   bus,
   input  logic                       vsd_sel,
   input  logic                       sd_act,
   output logic                       sd_sck,
   output logic                       sd_mosi,
   output logic                       sd_cs,
   input  logic                       sd_miso,
   output logic                       vsd_sck,
   output logic                       vsd_mosi,
   output logic                       vsd_ss,
   input  logic                       vsd_miso,
   output logic                       led_user,
   output msx_storage_pkg::led_disk_t led_disk
);

   // =======================================================================
   // Physical socket
   // =======================================================================

   // Socket is deselected and quiet while the image is in use
   assign sd_cs   = vsd_sel | bus.ss;
   assign sd_sck  = bus.sck  & ~vsd_sel;
   assign sd_mosi = bus.mosi & ~vsd_sel;

   // =======================================================================
   // Virtual card
   // =======================================================================

   assign vsd_sck  = bus.sck;
   assign vsd_mosi = bus.mosi;
   // Held deselected unless the image is mounted
   assign vsd_ss   = ~vsd_sel | bus.ss;

   // Reply from whichever card is active
   assign bus.miso = vsd_sel ? vsd_miso : sd_miso;

   // =======================================================================
   // LEDs
   // =======================================================================

   // User LED shows image traffic, disk LED shows socket traffic
   assign led_user = vsd_sel & sd_act;
   assign led_disk = {1'b1, ~vsd_sel & sd_act};

endmodule

// File: rtl/msx_storage_top.sv
// Storage and cassette control top level with SPI bus wiring
`timescale 1ns/1ps

module msx_storage_top (
   input  logic                          clock_bus,
   input  logic                          rst,

   // Expansion slot SPI master
   input  logic                          ese_sck,
   input  logic                          ese_mosi,
   input  logic                          ese_ss,
   input  logic                          ese_enable,
   output logic                          ese_miso,

   // Built-in MegaSD SPI master
   input  logic                          megasd_sck,
   input  logic                          megasd_mosi,
   output logic                          megasd_miso,

   // Image mount from the host
   input  logic                          img_mounted,
   input  msx_storage_pkg::img_size_t    img_size,

   // Physical card socket
   output logic                          sd_sck,
   output logic                          sd_mosi,
   output logic                          sd_cs,
   input  logic                          sd_miso,

   // Virtual card
   output logic                          vsd_sck,
   output logic                          vsd_mosi,
   output logic                          vsd_ss,
   input  logic                          vsd_miso,

   output logic                          led_user,
   output msx_storage_pkg::led_disk_t    led_disk,

   // Cassette
   input  logic                          ioctl_download,
   input  msx_storage_pkg::ioctl_index_t ioctl_index,
   input  logic                          tape_rewind_req,
   input  logic                          cas_motor,
   output logic                          tape_play,
   output logic                          tape_rewind,
   output logic                          tape_enable
);

   logic vsd_sel;
   logic sd_act;

   spi_bus_if ese_bus();
   spi_bus_if megasd_bus();
   spi_bus_if merged_bus();

   // ======================================================================
   // Master buses from the pins
   // ======================================================================

   assign ese_bus.sck    = ese_sck;
   assign ese_bus.mosi   = ese_mosi;
   assign ese_bus.ss     = ese_ss;
   assign ese_bus.enable = ese_enable;
   assign ese_miso       = ese_bus.miso;

   // MegaSD only has clock and data
   assign megasd_bus.sck  = megasd_sck;
   assign megasd_bus.mosi = megasd_mosi;
   assign megasd_miso     = megasd_bus.miso;

   // ======================================================================
   // SD path
   // ======================================================================

   sd_source_select u_source_select (
      .clock_bus   (clock_bus),
      .rst         (rst),
      .ese         (ese_bus),
      .megasd      (megasd_bus),
      .merged      (merged_bus),
      .img_mounted (img_mounted),
      .img_size    (img_size),
      .vsd_sel     (vsd_sel)
   );

   sd_activity_monitor u_activity (
      .clock_bus (clock_bus),
      .rst       (rst),
      .bus       (merged_bus),
      .sd_act    (sd_act)
   );

   sd_port_mux u_port_mux (
      .bus      (merged_bus),
      .vsd_sel  (vsd_sel),
      .sd_act   (sd_act),
      .sd_sck   (sd_sck),
      .sd_mosi  (sd_mosi),
      .sd_cs    (sd_cs),
      .sd_miso  (sd_miso),
      .vsd_sck  (vsd_sck),
      .vsd_mosi (vsd_mosi),
      .vsd_ss   (vsd_ss),
      .vsd_miso (vsd_miso),
      .led_user (led_user),
      .led_disk (led_disk)
   );

   // ======================================================================
   // Cassette
   // ======================================================================

   tape_control u_tape (
      .clock_bus       (clock_bus),
      .rst             (rst),
      .ioctl_download  (ioctl_download),
      .ioctl_index     (ioctl_index),
      .tape_rewind_req (tape_rewind_req),
      .cas_motor       (cas_motor),
      .tape_play       (tape_play),
      .tape_rewind     (tape_rewind),
      .tape_enable     (tape_enable)
   );

endmodule

// File: test/tb_msx_storage.sv
// Testbench for msx_storage_top with reference model, LFSR stimulus and compare process
`timescale 1ns/1ps
`include "msx_storage_consts.svh"

module tb_msx_storage;

   // About four activity hold periods plus margin for the SPI and tape phases
   localparam int MAX_CYCLES = 20000;

   typedef struct packed {
      logic sd_sck;
      logic sd_mosi;
      logic sd_cs;
      logic vsd_sck;
      logic vsd_mosi;
      logic vsd_ss;
      logic miso;
      logic play;
      logic rewind;
      logic enable;
   } expect_t;

   logic clock_bus = 1'b0;
   logic rst;
   logic ese_sck, ese_mosi, ese_ss, ese_enable, ese_miso;
   logic megasd_sck, megasd_mosi, megasd_miso;
   logic img_mounted;
   msx_storage_pkg::img_size_t img_size;
   logic sd_sck, sd_mosi, sd_cs, sd_miso;
   logic vsd_sck, vsd_mosi, vsd_ss, vsd_miso;
   logic led_user;
   msx_storage_pkg::led_disk_t led_disk;
   logic ioctl_download;
   msx_storage_pkg::ioctl_index_t ioctl_index;
   logic tape_rewind_req, cas_motor, tape_play, tape_rewind, tape_enable;

   // Model state
   logic sel_m;
   msx_storage_pkg::tape_state_t tape_m;
   logic req_q;
   logic motor_q;

   logic [15:0] lfsr = 16'd15024;
   int mismatch_count = 0;
   int fail_count = 0;
   int cycles = 0;

   msx_storage_top UUT (.*);

   always #4 clock_bus = ~clock_bus;

   // ========================================================================
   // Stimulus helpers
   // ========================================================================

   // Galois LFSR, x^16 + x^14 + x^13 + x^11 + 1
   function automatic logic rand_bit();
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
      return lfsr[0];
   endfunction

   function automatic logic [63:0] rand_bits(input int width);
      logic [63:0] v;
      v = '0;
      for (int i = 0; i < width; i++) begin
         v = {v[62:0], rand_bit()};
      end
      return v;
   endfunction

   task automatic drive_spi_random(input int n);
      repeat (n) begin
         @(posedge clock_bus);
         ese_enable  <= rand_bit();
         ese_sck     <= rand_bit();
         ese_mosi    <= rand_bit();
         ese_ss      <= rand_bit();
         megasd_sck  <= rand_bit();
         megasd_mosi <= rand_bit();
         sd_miso     <= rand_bit();
         vsd_miso    <= rand_bit();
      end
   endtask

   task automatic mount_image(input logic [63:0] size);
      @(posedge clock_bus);
      img_mounted <= 1'b1;
      img_size    <= size;
      @(posedge clock_bus);
      img_mounted <= 1'b0;
   endtask

   task automatic run_download(input logic [15:0] index, input int len);
      @(posedge clock_bus);
      ioctl_download <= 1'b1;
      ioctl_index    <= index;
      repeat (len) @(posedge clock_bus);
      ioctl_download <= 1'b0;
      repeat (len) begin
         @(posedge clock_bus);
         cas_motor <= rand_bit();
      end
   endtask

   // ========================================================================
   // Reference model
   // ========================================================================

   function automatic msx_storage_pkg::tape_state_t tape_next(
      input msx_storage_pkg::tape_state_t st);
      logic cas;
      cas = ioctl_download &&
         (ioctl_index[`CAS_INDEX_BITS-1:0] == `CAS_INDEX_BITS'(`CAS_IOCTL_INDEX));
      if (st == msx_storage_pkg::TAPE_LOADING) begin
         return cas ? msx_storage_pkg::TAPE_LOADING : msx_storage_pkg::TAPE_READY;
      end
      return cas ? msx_storage_pkg::TAPE_LOADING : st;
   endfunction

   function automatic expect_t reference_outputs(input logic sel,
      input msx_storage_pkg::tape_state_t st, input logic req, input logic motor);
      expect_t e;
      logic sck, mosi, ss;
      sck  = ese_enable ? ese_sck : megasd_sck;
      mosi = ese_enable ? ese_mosi : megasd_mosi;
      ss   = ese_enable ? ese_ss : 1'b0;
      e.sd_sck   = sck & ~sel;
      e.sd_mosi  = mosi & ~sel;
      e.sd_cs    = sel | ss;
      e.vsd_sck  = sck;
      e.vsd_mosi = mosi;
      e.vsd_ss   = ~sel | ss;
      e.miso     = sel ? vsd_miso : sd_miso;
      e.rewind   = req | (st == msx_storage_pkg::TAPE_LOADING);
      e.enable   = st == msx_storage_pkg::TAPE_READY;
      e.play     = (st == msx_storage_pkg::TAPE_READY) & ~motor;
      return e;
   endfunction

   always @(posedge clock_bus) begin
      if (rst) begin
         sel_m   <= 1'b0;
         tape_m  <= msx_storage_pkg::TAPE_EMPTY;
         req_q   <= 1'b0;
         motor_q <= 1'b0;
      end else begin
         if (img_mounted) sel_m <= (img_size != '0);
         tape_m  <= tape_next(tape_m);
         req_q   <= tape_rewind_req;
         motor_q <= cas_motor;
      end
   end

   // ========================================================================
   // Checking
   // ========================================================================

   task automatic check_value(input string name, input logic [63:0] got,
      input logic [63:0] want);
      if (got !== want) begin
         mismatch_count++;
         $display("mismatch %s: got %0h expected %0h at %0t", name, got, want, $time);
      end
   endtask

   always @(negedge clock_bus) begin
      expect_t e;
      if (!rst) begin
         e = reference_outputs(sel_m, tape_m, req_q, motor_q);
         check_value("sd_sck", sd_sck, e.sd_sck);
         check_value("sd_mosi", sd_mosi, e.sd_mosi);
         check_value("sd_cs", sd_cs, e.sd_cs);
         check_value("vsd_sck", vsd_sck, e.vsd_sck);
         check_value("vsd_mosi", vsd_mosi, e.vsd_mosi);
         check_value("vsd_ss", vsd_ss, e.vsd_ss);
         check_value("ese_miso", ese_miso, e.miso);
         check_value("megasd_miso", megasd_miso, e.miso);
         check_value("tape_play", tape_play, e.play);
         check_value("tape_rewind", tape_rewind, e.rewind);
         check_value("tape_enable", tape_enable, e.enable);
         check_value("led_disk[1]", led_disk[1], 1'b1);
         // LED of the unused card stays dark
         if (sel_m) check_value("led_disk[0]", led_disk[0], 1'b0);
         else check_value("led_user", led_user, 1'b0);
      end
   end

   function automatic logic led_level(input logic virt);
      return virt ? led_user : led_disk[0];
   endfunction

   // One data line edge, then rise and fall times counted from that edge
   task automatic measure_activity(input logic virt, input string name);
      int n;
      @(negedge clock_bus);
      while (led_level(virt)) @(negedge clock_bus);
      @(posedge clock_bus);
      // Socket sees a MOSI edge, the image a MISO edge
      if (virt) vsd_miso <= ~vsd_miso;
      else megasd_mosi <= ~megasd_mosi;
      n = 0;
      do begin
         @(negedge clock_bus);
         n++;
      end while (!led_level(virt) && n < 8);
      if (n > 3) begin
         fail_count++;
         $display("%s did not light within 3 cycles of SPI traffic", name);
      end
      do begin
         @(negedge clock_bus);
         n++;
      end while (led_level(virt) && n < `SD_ACT_HOLD + 16);
      if (n < `SD_ACT_HOLD || n > `SD_ACT_HOLD + 3) begin
         fail_count++;
         $display("%s went dark after %0d quiet cycles instead of %0d to %0d",
            name, n, `SD_ACT_HOLD, `SD_ACT_HOLD + 3);
      end
   endtask

   always @(posedge clock_bus) begin
      cycles++;
      if (cycles >= MAX_CYCLES) begin
         $display("timeout after %0d cycles, %0d mismatches, %0d other failures",
            cycles, mismatch_count, fail_count);
         $display("TEST FAIL");
         $finish;
      end
   end

   // ========================================================================
   // Test sequence
   // ========================================================================

   initial begin
      logic [63:0] size;
      rst = 1'b1;
      {ese_sck, ese_mosi, ese_ss, ese_enable, megasd_sck, megasd_mosi} = '0;
      {sd_miso, vsd_miso, img_mounted, ioctl_download} = '0;
      {tape_rewind_req, cas_motor} = '0;
      img_size    = '0;
      ioctl_index = '0;
      repeat (2) @(posedge clock_bus);
      rst <= 1'b0;

      @(negedge clock_bus);
      check_value("led_disk", led_disk, 2'b10);
      check_value("led_user", led_user, 1'b0);

      // Physical card, then virtual card, then back
      drive_spi_random(100);
      size = rand_bits(64);
      if (size == '0) size = 64'd1;
      mount_image(size);
      drive_spi_random(100);
      mount_image('0);
      drive_spi_random(50);

      // Cassette downloads
      run_download(16'd6, 6);
      run_download(16'd5, 8);
      run_download(16'd6, 6);
      @(posedge clock_bus);
      tape_rewind_req <= 1'b1;
      @(posedge clock_bus);
      tape_rewind_req <= 1'b0;
      // Upper index bits do not count
      run_download(16'h0045, 5);
      run_download(16'd5, 5);

      // Quiet bus for activity timing
      @(posedge clock_bus);
      {ese_sck, ese_mosi, ese_ss, ese_enable} <= '0;
      {megasd_sck, megasd_mosi, sd_miso, vsd_miso} <= '0;
      measure_activity(1'b0, "led_disk[0]");
      mount_image(64'h0000_0000_0010_0000);
      measure_activity(1'b1, "led_user");
      mount_image('0);
      repeat (4) @(posedge clock_bus);

      $display("checks done: %0d mismatches, %0d other failures",
         mismatch_count, fail_count);
      if (mismatch_count == 0 && fail_count == 0) begin
         $display("TEST PASS");
      end else begin
         $display("TEST FAIL");
      end
      $finish;
   end

endmodule

// File: tb.f
+incdir+rtl
rtl/msx_storage_pkg.sv
rtl/spi_bus_if.sv
rtl/sd_source_select.sv
rtl/sd_activity_monitor.sv
rtl/tape_control.sv
rtl/sd_port_mux.sv
rtl/msx_storage_top.sv
test/tb_msx_storage.sv
